// File: Bender.yml
package:
  name: glay_kernel

sources:
  # Package first, then the RTL bottom up
  - glay_kernel_pkg.sv
  - kernel_control.sv
  - vertex_engine.sv
  - edge_engine.sv
  - cu_result_merge.sv
  - glay_kernel_top.sv
  - target: test
    files:
      - glay_kernel_tb.sv

// File: cu_result_merge.sv
// ----------------------------------------------------------
// Compute unit result merge
// Joins engine completion, latches both sums, checks degree
// total against edge count, reports setup, busy and done
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module cu_result_merge import glay_kernel_pkg::*; (
    input  wire logic   ap_clk,
    input  wire logic   areset_control,
    input  wire logic   vertex_running,
    input  wire logic   vertex_finished,
    input  wire logic   edge_running,
    input  wire logic   edge_finished,
    input  wire sum_t   degree_in,
    input  wire sum_t   edge_id_in,
    input  wire count_t edges_seen,
    output logic        cu_setup,
    output logic        cu_done,
    output logic        cu_busy,
    output sum_t        degree_sum,
    output sum_t        edge_sum,
    output logic        degree_mismatch
);

    logic both_finished;
    logic both_finished_d;
    logic any_running;
    logic all_quiet;
    logic join_event;

    assign both_finished = vertex_finished & edge_finished;
    assign any_running   = vertex_running | edge_running;
    assign all_quiet     = ~any_running & ~vertex_finished & ~edge_finished;
    // First cycle of joint completion
    assign join_event    = both_finished & ~both_finished_d;

    // ------------------------------------------------------------
    // Status levels to kernel control
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            both_finished_d <= 1'b0;
            cu_setup        <= 1'b1;
            cu_done         <= 1'b0;
            cu_busy         <= 1'b0;
        end else begin
            both_finished_d <= both_finished;
            cu_setup        <= all_quiet;
            cu_done         <= both_finished;
            cu_busy         <= any_running;
        end
    end

    // ------------------------------------------------------------
    // Result latch, held until next joint completion
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            degree_sum      <= '0;
            edge_sum        <= '0;
            degree_mismatch <= 1'b0;
        end else if (join_event) begin
            degree_sum      <= degree_in;
            edge_sum        <= edge_id_in;
            // Degree total should equal edges accepted
            degree_mismatch <= (degree_in != sum_t'(edges_seen));
        end
    end

endmodule : cu_result_merge

`default_nettype wire

// File: edge_engine.sv
// ----------------------------------------------------------
// Edge engine
// Sums byte-order-corrected neighbour ids, counts edges
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module edge_engine import glay_kernel_pkg::*; (
    input  wire logic   ap_clk,
    input  wire logic   areset_control,
    input  wire logic   descriptor_valid,
    input  wire logic   endian,
    input  wire count_t desc_edge_count,
    input  wire logic   edge_valid,
    input  wire word_t  edge_data,
    output logic        running,
    output logic        finished,
    output sum_t        edge_id_sum,
    output count_t      edges_seen
);

    engine_state_t state;
    logic          descriptor_valid_d;
    logic          arm;
    count_t        edge_target;
    word_t         neighbour_id;

    assign arm          = descriptor_valid & ~descriptor_valid_d;
    assign neighbour_id = endian ? endian_swap(edge_data) : edge_data;

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            state              <= ENG_IDLE;
            descriptor_valid_d <= 1'b0;
            edge_target        <= '0;
            edges_seen         <= '0;
            edge_id_sum        <= '0;
        end else begin
            descriptor_valid_d <= descriptor_valid;
            case (state)
                ENG_IDLE: begin
                    if (arm) begin
                        edge_target <= desc_edge_count;
                        edges_seen  <= '0;
                        edge_id_sum <= '0;
                        state <= (desc_edge_count == '0) ? ENG_HOLD : ENG_RUN;
                    end
                end
                // Beat count doubles as the merge check value
                ENG_RUN: begin
                    if (edge_valid) begin
                        edge_id_sum <= edge_id_sum + neighbour_id;
                        edges_seen  <= edges_seen + 1'b1;
                        if (edges_seen + 1'b1 == edge_target) begin
                            state <= ENG_HOLD;
                        end
                    end
                end
                ENG_HOLD: begin
                    if (!descriptor_valid) begin
                        state <= ENG_IDLE;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    assign running  = (state == ENG_RUN);
    assign finished = (state == ENG_HOLD);

endmodule : edge_engine

`default_nettype wire

// File: glay_kernel.f
glay_kernel_pkg.sv
kernel_control.sv
vertex_engine.sv
edge_engine.sv
cu_result_merge.sv
glay_kernel_top.sv
glay_kernel_tb.sv

// File: glay_kernel_pkg.sv
// ----------------------------------------------------------
// GLay kernel slot shared definitions
// Widths, state encodings, endian flag position and the
// byte-swap helper used by the compute engines
// ----------------------------------------------------------

`default_nettype none

package glay_kernel_pkg;

    // ------------------------------------------------------------
    // Data widths
    // ------------------------------------------------------------
    // Vertex or edge count, also beats seen
    typedef logic [15:0] count_t;
    // One stream word, degree or neighbour id
    typedef logic [31:0] word_t;
    // Accumulated sum, wraps modulo 2^32
    typedef logic [31:0] sum_t;
    // Descriptor flag byte
    typedef logic [7:0]  flags_t;

    // Endian flag position in the flag byte
    localparam int ENDIAN_FLAG_BIT = 0;

    // ------------------------------------------------------------
    // State encodings
    // ------------------------------------------------------------
    // ap_ctrl_chain sync machine
    typedef enum logic [2:0] {
        CTRL_RESET,
        CTRL_IDLE,
        CTRL_SETUP,
        CTRL_READY,
        CTRL_START,
        CTRL_BUSY,
        CTRL_DONE
    } ctrl_chain_state_t;

    // Shared by vertex and edge engines
    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_RUN,
        ENG_HOLD
    } engine_state_t;

    // Reverse the four bytes of a big-endian word
    function automatic word_t endian_swap(input word_t data);
        return {data[7:0], data[15:8], data[23:16], data[31:24]};
    endfunction

endpackage : glay_kernel_pkg

`default_nettype wire

// File: glay_kernel_tb.sv
// ----------------------------------------------------------
// GLay kernel slot testbench
// Directed jobs through the ap_ctrl_chain shell, sums and
// degree check compared against a reference model
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module glay_kernel_tb import glay_kernel_pkg::*; ();

    // Limit for every wait loop, in clock cycles
    localparam int WAIT_CYCLES = 200;

    logic   ap_clk;
    logic   areset_control;
    logic   ap_start;
    count_t descriptor_vertex_count;
    count_t descriptor_edge_count;
    flags_t descriptor_flags;
    logic   vertex_valid;
    word_t  vertex_data;
    logic   edge_valid;
    word_t  edge_data;
    logic   ap_ready;
    logic   ap_idle;
    logic   ap_done;
    logic   cu_busy;
    sum_t   degree_sum;
    sum_t   edge_sum;
    logic   degree_mismatch;

    // Current job and its expected results
    word_t  vertex_words[$];
    word_t  edge_words[$];
    sum_t   exp_degree;
    sum_t   exp_edge;
    logic   exp_mismatch;
    logic   ready_seen;

    // Bookkeeping
    bit     aborted;
    int     error_count;
    int     tests_passed;
    int     tests_failed;

    glay_kernel_top glay_kernel_top_i (
        .ap_clk                  (ap_clk),
        .areset_control          (areset_control),
        .ap_start                (ap_start),
        .descriptor_vertex_count (descriptor_vertex_count),
        .descriptor_edge_count   (descriptor_edge_count),
        .descriptor_flags        (descriptor_flags),
        .vertex_valid            (vertex_valid),
        .vertex_data             (vertex_data),
        .edge_valid              (edge_valid),
        .edge_data               (edge_data),
        .ap_ready                (ap_ready),
        .ap_idle                 (ap_idle),
        .ap_done                 (ap_done),
        .cu_busy                 (cu_busy),
        .degree_sum              (degree_sum),
        .edge_sum                (edge_sum),
        .degree_mismatch         (degree_mismatch)
    );

    // 4 ns clock
    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    // Byte reversal of a big-endian word
    function automatic word_t byte_reverse(input word_t w);
        word_t r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = w[8*(3-b) +: 8];
        end
        return r;
    endfunction

    // Random degrees, edge count is degree total plus an offset
    task automatic build_job(input int vertices, input int edge_offset);
        int total;
        total = 0;
        vertex_words.delete();
        edge_words.delete();
        for (int i = 0; i < vertices; i++) begin
            vertex_words.push_back(word_t'($urandom_range(1, 6)));
            total += vertex_words[i];
        end
        for (int i = 0; i < total + edge_offset; i++) begin
            edge_words.push_back($urandom);
        end
    endtask

    // Wrapping 32-bit sums, degree total against edge count
    task automatic model_job(input bit big_endian);
        exp_degree = '0;
        exp_edge   = '0;
        foreach (vertex_words[i]) begin
            exp_degree += big_endian ? byte_reverse(vertex_words[i]) : vertex_words[i];
        end
        foreach (edge_words[i]) begin
            exp_edge += big_endian ? byte_reverse(edge_words[i]) : edge_words[i];
        end
        exp_mismatch = (exp_degree != sum_t'(edge_words.size()));
    endtask

    // ------------------------------------------------------------
    // Drive, wait and check helpers
    // ------------------------------------------------------------
    // Inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge ap_clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (!aborted) begin
            assert (actual === expected) else begin
                $display("error: %s expected %h got %h", name, expected, actual);
                error_count++;
            end
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not rise within %0d cycles", what, WAIT_CYCLES);
        aborted = 1'b1;
    endtask

    // Present descriptor, raise ap_start until ap_ready, optional stray beats
    task automatic start_job(input flags_t flags, input bit stray);
        int   cycles;
        logic done_prev;
        logic done_rose;
        cycles     = 0;
        done_prev  = ap_done;
        done_rose  = 1'b0;
        ready_seen = 1'b0;
        if (!aborted) begin
            descriptor_vertex_count = count_t'(vertex_words.size());
            descriptor_edge_count   = count_t'(edge_words.size());
            descriptor_flags        = flags;
            ap_start                = 1'b1;
            while (!ap_ready && cycles < WAIT_CYCLES) begin
                // Engines not armed yet, these beats must be dropped
                vertex_valid = stray;
                vertex_data  = $urandom;
                edge_valid   = stray;
                edge_data    = $urandom;
                tick();
                cycles++;
                // A new ap_done ahead of ap_ready breaks the handshake order
                if (ap_done && !done_prev) begin
                    done_rose = 1'b1;
                end
                done_prev = ap_done;
            end
            ap_start     = 1'b0;
            vertex_valid = 1'b0;
            edge_valid   = 1'b0;
            if (ap_ready) begin
                ready_seen = ~done_rose;
                // Leaving DONE drops ap_done as ap_ready rises
                check_value("ap_done", 1'b0, ap_done);
            end else begin
                report_timeout("ap_ready");
            end
        end
    endtask

    // Both streams with random gaps once the engines run
    task automatic send_streams();
        int cycles;
        int vi;
        int ei;
        cycles = 0;
        vi     = 0;
        ei     = 0;
        if (!aborted && (vertex_words.size() != 0 || edge_words.size() != 0)) begin
            while (!cu_busy && cycles < WAIT_CYCLES) begin
                tick();
                cycles++;
            end
            if (!cu_busy) begin
                report_timeout("cu_busy");
            end else begin
                while (vi < vertex_words.size() || ei < edge_words.size()) begin
                    vertex_valid = 1'b0;
                    edge_valid   = 1'b0;
                    if (vi < vertex_words.size() && $urandom_range(0, 3) != 0) begin
                        vertex_valid = 1'b1;
                        vertex_data  = vertex_words[vi];
                        vi++;
                    end
                    if (ei < edge_words.size() && $urandom_range(0, 3) != 0) begin
                        edge_valid = 1'b1;
                        edge_data  = edge_words[ei];
                        ei++;
                    end
                    tick();
                end
                vertex_valid = 1'b0;
                edge_valid   = 1'b0;
            end
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        if (!aborted) begin
            while (!ap_done && cycles < WAIT_CYCLES) begin
                tick();
                cycles++;
            end
            if (!ap_done) begin
                report_timeout("ap_done");
            end else begin
                assert (ready_seen) else begin
                    $display("ap_done rose before ap_ready was seen for this job");
                    error_count++;
                end
            end
        end
    endtask

    task automatic check_results();
        check_value("degree_sum", exp_degree, degree_sum);
        check_value("edge_sum", exp_edge, edge_sum);
        check_value("degree_mismatch", exp_mismatch, degree_mismatch);
    endtask

    task automatic run_job(input flags_t flags, input bit stray);
        start_job(flags, stray);
        send_streams();
        wait_done();
        check_results();
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (aborted || error_count != errors_before) begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, error_count - errors_before);
        end else begin
            tests_passed++;
            $display("test %s: ok", name);
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic test_reset();
        int errors_before;
        errors_before = error_count;
        check_value("ap_idle", 1'b1, ap_idle);
        check_value("ap_ready", 1'b0, ap_ready);
        check_value("ap_done", 1'b0, ap_done);
        check_value("cu_busy", 1'b0, cu_busy);
        check_value("degree_mismatch", 1'b0, degree_mismatch);
        check_value("degree_sum", 32'h0, degree_sum);
        check_value("edge_sum", 32'h0, edge_sum);
        end_test("reset values", errors_before);
    endtask

    task automatic test_little_endian();
        int errors_before;
        errors_before = error_count;
        build_job(8, 0);
        model_job(1'b0);
        run_job(8'h00, 1'b0);
        // Done and idle hold while ap_start stays low
        repeat (20) begin
            tick();
            check_value("ap_done", 1'b1, ap_done);
            check_value("ap_idle", 1'b1, ap_idle);
        end
        end_test("little-endian job", errors_before);
    endtask

    // Same words as the previous job, flag bit 0 set
    task automatic test_big_endian();
        int errors_before;
        errors_before = error_count;
        model_job(1'b1);
        run_job(8'h01, 1'b0);
        end_test("big-endian job", errors_before);
    endtask

    task automatic test_mismatch();
        int errors_before;
        errors_before = error_count;
        build_job(5, 3);
        model_job(1'b0);
        run_job(8'h00, 1'b1);
        end_test("degree mismatch with stray beats", errors_before);
    endtask

    task automatic test_chained();
        int   errors_before;
        sum_t first_degree;
        sum_t first_edge;
        errors_before = error_count;
        build_job(4, 0);
        model_job(1'b0);
        run_job(8'h00, 1'b0);
        first_degree = exp_degree;
        first_edge   = exp_edge;
        // Second start while ap_done is still high
        check_value("ap_done", 1'b1, ap_done);
        build_job(6, 0);
        start_job(8'h00, 1'b0);
        // Armed but no beats yet, first result still held
        check_value("degree_sum", first_degree, degree_sum);
        check_value("edge_sum", first_edge, edge_sum);
        model_job(1'b0);
        send_streams();
        wait_done();
        check_results();
        end_test("chained jobs", errors_before);
    endtask

    task automatic test_empty();
        int errors_before;
        errors_before = error_count;
        vertex_words.delete();
        edge_words.delete();
        model_job(1'b0);
        run_job(8'h00, 1'b0);
        end_test("zero-count job", errors_before);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(32'hc8bd));
        aborted                 = 1'b0;
        error_count             = 0;
        tests_passed            = 0;
        tests_failed            = 0;
        ready_seen              = 1'b0;
        areset_control          = 1'b1;
        ap_start                = 1'b0;
        descriptor_vertex_count = '0;
        descriptor_edge_count   = '0;
        descriptor_flags        = '0;
        vertex_valid            = 1'b0;
        vertex_data             = '0;
        edge_valid              = 1'b0;
        edge_data               = '0;
        repeat (16) tick();
        areset_control = 1'b0;
        tick();

        test_reset();
        if (!aborted) test_little_endian();
        if (!aborted) test_big_endian();
        if (!aborted) test_mismatch();
        if (!aborted) test_chained();
        if (!aborted) test_empty();

        $display("summary: %0d tests ok, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (aborted || tests_failed != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule : glay_kernel_tb

`default_nettype wire

// File: glay_kernel_top.sv
// ----------------------------------------------------------
// GLay kernel slot top level
// Control shell, vertex and edge engines, result merge
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module glay_kernel_top import glay_kernel_pkg::*; (
    input  wire logic   ap_clk,
    input  wire logic   areset_control,
    input  wire logic   ap_start,
    input  wire count_t descriptor_vertex_count,
    input  wire count_t descriptor_edge_count,
    input  wire flags_t descriptor_flags,
    input  wire logic   vertex_valid,
    input  wire word_t  vertex_data,
    input  wire logic   edge_valid,
    input  wire word_t  edge_data,
    output logic        ap_ready,
    output logic        ap_idle,
    output logic        ap_done,
    output logic        cu_busy,
    output sum_t        degree_sum,
    output sum_t        edge_sum,
    output logic        degree_mismatch
);

    // Control to engines
    logic   descriptor_valid;
    logic   endian;
    count_t desc_vertex_count;
    count_t desc_edge_count;

    // Engines to merge
    logic   vertex_running;
    logic   vertex_finished;
    logic   edge_running;
    logic   edge_finished;
    sum_t   vertex_degree_sum;
    sum_t   edge_id_sum;
    count_t edges_seen;

    // Merge back to control
    logic   cu_setup;
    logic   cu_done;

    kernel_control kernel_control_i (
        .ap_clk                  (ap_clk),
        .areset_control          (areset_control),
        .ap_start                (ap_start),
        .cu_setup                (cu_setup),
        .cu_done                 (cu_done),
        .descriptor_vertex_count (descriptor_vertex_count),
        .descriptor_edge_count   (descriptor_edge_count),
        .descriptor_flags        (descriptor_flags),
        .ap_ready                (ap_ready),
        .ap_idle                 (ap_idle),
        .ap_done                 (ap_done),
        .descriptor_valid        (descriptor_valid),
        .endian                  (endian),
        .desc_vertex_count       (desc_vertex_count),
        .desc_edge_count         (desc_edge_count)
    );

    vertex_engine vertex_engine_i (
        .ap_clk            (ap_clk),
        .areset_control    (areset_control),
        .descriptor_valid  (descriptor_valid),
        .endian            (endian),
        .desc_vertex_count (desc_vertex_count),
        .vertex_valid      (vertex_valid),
        .vertex_data       (vertex_data),
        .running           (vertex_running),
        .finished          (vertex_finished),
        .degree_sum        (vertex_degree_sum)
    );

    edge_engine edge_engine_i (
        .ap_clk           (ap_clk),
        .areset_control   (areset_control),
        .descriptor_valid (descriptor_valid),
        .endian           (endian),
        .desc_edge_count  (desc_edge_count),
        .edge_valid       (edge_valid),
        .edge_data        (edge_data),
        .running          (edge_running),
        .finished         (edge_finished),
        .edge_id_sum      (edge_id_sum),
        .edges_seen       (edges_seen)
    );

    cu_result_merge cu_result_merge_i (
        .ap_clk          (ap_clk),
        .areset_control  (areset_control),
        .vertex_running  (vertex_running),
        .vertex_finished (vertex_finished),
        .edge_running    (edge_running),
        .edge_finished   (edge_finished),
        .degree_in       (vertex_degree_sum),
        .edge_id_in      (edge_id_sum),
        .edges_seen      (edges_seen),
        .cu_setup        (cu_setup),
        .cu_done         (cu_done),
        .cu_busy         (cu_busy),
        .degree_sum      (degree_sum),
        .edge_sum        (edge_sum),
        .degree_mismatch (degree_mismatch)
    );

endmodule : glay_kernel_top

`default_nettype wire

// File: kernel_control.sv
// ----------------------------------------------------------
// Kernel control, ap_ctrl_chain host protocol
// Registers host inputs, runs the chain-sync FSM, stages the
// descriptor and decodes the endian flag
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module kernel_control import glay_kernel_pkg::*; (
    input  wire logic   ap_clk,
    input  wire logic   areset_control,
    input  wire logic   ap_start,
    input  wire logic   cu_setup,
    input  wire logic   cu_done,
    input  wire count_t descriptor_vertex_count,
    input  wire count_t descriptor_edge_count,
    input  wire flags_t descriptor_flags,
    output logic        ap_ready,
    output logic        ap_idle,
    output logic        ap_done,
    output logic        descriptor_valid,
    output logic        endian,
    output count_t      desc_vertex_count,
    output count_t      desc_edge_count
);

    // Registered control inputs
    logic ap_start_reg;
    logic cu_setup_reg;
    logic cu_done_reg;

    // First descriptor stage
    count_t vertex_count_reg;
    count_t edge_count_reg;
    flags_t flags_reg;

    // State decode, first output stage
    logic ap_ready_dec;
    logic ap_idle_dec;
    logic ap_done_dec;
    logic descriptor_valid_dec;
    logic endian_dec;

    ctrl_chain_state_t current_state;
    ctrl_chain_state_t next_state;

    // ------------------------------------------------------------
    // Input registers
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_start_reg <= 1'b0;
            cu_setup_reg <= 1'b1;
            cu_done_reg  <= 1'b0;
        end else begin
            ap_start_reg <= ap_start;
            cu_setup_reg <= cu_setup;
            cu_done_reg  <= cu_done;
        end
    end

    // Descriptor payload, two stages
    always_ff @(posedge ap_clk) begin
        vertex_count_reg  <= descriptor_vertex_count;
        edge_count_reg    <= descriptor_edge_count;
        flags_reg         <= descriptor_flags;
        desc_vertex_count <= vertex_count_reg;
        desc_edge_count   <= edge_count_reg;
    end

    // ------------------------------------------------------------
    // Chain-sync FSM
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            current_state <= CTRL_RESET;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            CTRL_RESET: next_state = CTRL_IDLE;
            CTRL_IDLE:  next_state = CTRL_SETUP;
            // Wait for the host to start a job
            CTRL_SETUP: begin
                if (ap_start_reg) begin
                    next_state = CTRL_READY;
                end
            end
            // Engines must be back in idle before arming
            CTRL_READY: begin
                if (cu_setup_reg) begin
                    next_state = CTRL_START;
                end
            end
            CTRL_START: next_state = CTRL_BUSY;
            CTRL_BUSY: begin
                if (cu_done_reg) begin
                    next_state = CTRL_DONE;
                end
            end
            // Chained start goes straight back to READY
            CTRL_DONE: begin
                if (ap_start_reg) begin
                    next_state = CTRL_READY;
                end
            end
            default: next_state = CTRL_RESET;
        endcase
    end

    // ------------------------------------------------------------
    // State decode
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_ready_dec         <= 1'b0;
            ap_idle_dec          <= 1'b1;
            ap_done_dec          <= 1'b0;
            descriptor_valid_dec <= 1'b0;
            endian_dec           <= 1'b0;
        end else begin
            // Defaults cover RESET, IDLE and SETUP
            ap_ready_dec         <= 1'b0;
            ap_idle_dec          <= 1'b1;
            ap_done_dec          <= 1'b0;
            descriptor_valid_dec <= 1'b0;
            endian_dec           <= 1'b0;
            case (current_state)
                CTRL_READY: begin
                    ap_ready_dec <= 1'b1;
                    ap_idle_dec  <= 1'b0;
                end
                CTRL_START, CTRL_BUSY: begin
                    ap_idle_dec          <= 1'b0;
                    descriptor_valid_dec <= 1'b1;
                    endian_dec           <= flags_reg[ENDIAN_FLAG_BIT];
                end
                CTRL_DONE: ap_done_dec <= 1'b1;
                default: ;
            endcase
        end
    end

    // Second output stage, glitch-free levels to the host
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_ready         <= 1'b0;
            ap_idle          <= 1'b1;
            ap_done          <= 1'b0;
            descriptor_valid <= 1'b0;
            endian           <= 1'b0;
        end else begin
            ap_ready         <= ap_ready_dec;
            ap_idle          <= ap_idle_dec;
            ap_done          <= ap_done_dec;
            descriptor_valid <= descriptor_valid_dec;
            endian           <= endian_dec;
        end
    end

endmodule : kernel_control

`default_nettype wire

// File: vertex_engine.sv
// ----------------------------------------------------------
// Vertex engine
// Sums byte-order-corrected vertex degrees for one job
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module vertex_engine import glay_kernel_pkg::*; (
    input  wire logic   ap_clk,
    input  wire logic   areset_control,
    input  wire logic   descriptor_valid,
    input  wire logic   endian,
    input  wire count_t desc_vertex_count,
    input  wire logic   vertex_valid,
    input  wire word_t  vertex_data,
    output logic        running,
    output logic        finished,
    output sum_t        degree_sum
);

    engine_state_t state;
    logic          descriptor_valid_d;
    logic          arm;
    count_t        vertex_target;
    count_t        beats;
    word_t         degree;

    // Arm on rising edge of descriptor valid
    assign arm    = descriptor_valid & ~descriptor_valid_d;
    assign degree = endian ? endian_swap(vertex_data) : vertex_data;

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            state              <= ENG_IDLE;
            descriptor_valid_d <= 1'b0;
            vertex_target      <= '0;
            beats              <= '0;
            degree_sum         <= '0;
        end else begin
            descriptor_valid_d <= descriptor_valid;
            case (state)
                ENG_IDLE: begin
                    if (arm) begin
                        vertex_target <= desc_vertex_count;
                        beats         <= '0;
                        degree_sum    <= '0;
                        // Empty job finishes at once
                        state <= (desc_vertex_count == '0) ? ENG_HOLD : ENG_RUN;
                    end
                end
                ENG_RUN: begin
                    if (vertex_valid) begin
                        degree_sum <= degree_sum + degree;
                        beats      <= beats + 1'b1;
                        if (beats + 1'b1 == vertex_target) begin
                            state <= ENG_HOLD;
                        end
                    end
                end
                // Hold result until descriptor withdrawn
                ENG_HOLD: begin
                    if (!descriptor_valid) begin
                        state <= ENG_IDLE;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    assign running  = (state == ENG_RUN);
    assign finished = (state == ENG_HOLD);

endmodule : vertex_engine

`default_nettype wire
